// File: build.f
hdl/ras_pkg.sv
hdl/circular_buffer.sv
hdl/ras_decoder.sv
hdl/ras_checker.sv
hdl/ras_apb_regs.sv
hdl/ras_top.sv
verification/ras_asserts.sv
verification/tb_ras_top.sv

// File: Makefile
# Verilator build and run for the RAS predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_ras_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -Wno-fatal -j 0
PASS_MSG  ?= Simulation passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/tb_ras_top.sv
`default_nettype none

module tb_ras_top;
   timeunit 1ns;
   timeprecision 1ps;

   import ras_pkg::*;

   typedef struct packed {
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] instr;
      logic [XLEN-1:0] target;       // resolved jump target
      logic            exp_valid;
      logic [XLEN-1:0] exp_target;
   } row_t;

   localparam int N_ROWS      = 40;                            // rows over all segments
   localparam int N_APB       = 22;                            // transfers of 3 cycles each
   localparam int CYCLE_LIMIT = 2 * N_ROWS + 3 * N_APB + 200;
   localparam logic [4:0] ZERO = 5'd0;
   localparam logic [4:0] RA   = 5'd1;
   localparam logic [4:0] T0   = 5'd5;   // alternate link

   logic              s_clk;
   logic              s_resetn;
   logic              s_valid;
   logic [XLEN-1:0]   s_pc;
   logic [XLEN-1:0]   s_instr;
   logic [XLEN-1:0]   s_target;
   logic              s_psel;
   logic              s_penable;
   logic              s_pwrite;
   logic [APB_AW-1:0] s_paddr;
   logic [XLEN-1:0]   s_pwdata;
   logic [XLEN-1:0]   s_prdata;
   logic              s_pready;
   logic              s_pslverr;
   logic              s_pred_valid;
   logic [XLEN-1:0]   s_pred_target;

   row_t            rows[$];        // stimulus and expected prediction
   logic [XLEN-1:0] model_stk[$];   // reference stack with top at the back
   bit              model_en;
   int              n_hits;
   int              n_misses;
   int              n_empty;
   int              next_row;       // first row not yet applied
   int              n_errors;
   int              n_apb;
   int              cycle_cnt;
   integer          seed;

   ras_top uut (
      .s_clk_i(s_clk), .s_resetn_i(s_resetn), .s_valid_i(s_valid), .s_pc_i(s_pc),
      .s_instr_i(s_instr), .s_target_i(s_target), .s_psel_i(s_psel),
      .s_penable_i(s_penable), .s_pwrite_i(s_pwrite), .s_paddr_i(s_paddr),
      .s_pwdata_i(s_pwdata), .s_prdata_o(s_prdata), .s_pready_o(s_pready),
      .s_pslverr_o(s_pslverr), .s_pred_valid_o(s_pred_valid),
      .s_pred_target_o(s_pred_target));

   initial begin : clk_gen
      s_clk = 1'b0;
      forever #10 s_clk = ~s_clk;   // 20 ns period
   end

   function automatic logic [XLEN-1:0] enc_jal(input logic [4:0] rd);
      return {20'h0, rd, OPC_JAL};   // zero offset
   endfunction

   function automatic logic [XLEN-1:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
      return {12'h0, rs1, 3'b000, rd, OPC_JALR};
   endfunction

   task automatic report_fail(input string msg);
      n_errors++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   // append one row while the stack model steps along
   task automatic add_row(input logic [XLEN-1:0] instr, input bit do_push, input bit do_pop,
                          input bit use_top);
      row_t r;
      r.pc         = $random(seed) & 32'hFFFF_FFFC;
      r.instr      = instr;
      r.target     = $random(seed) & 32'hFFFF_FFFC;
      r.exp_valid  = 1'b0;
      r.exp_target = '0;
      if (model_en && do_pop) begin
         if (model_stk.size() == 0) begin
            n_empty++;                                    // nothing to predict
         end else begin
            r.exp_valid  = 1'b1;
            r.exp_target = model_stk[$];
            if (use_top) r.target = model_stk[$];        // well-behaved return
            if (r.target == r.exp_target) n_hits++;
            else n_misses++;
            if (!do_push) void'(model_stk.pop_back());
         end
      end
      if (model_en && do_push) begin
         if (do_pop && r.exp_valid) begin
            model_stk[$] = r.pc + 32'd4;                  // coroutine swaps the top
         end else begin
            model_stk.push_back(r.pc + 32'd4);
            if (model_stk.size() > RAS_DEPTH) void'(model_stk.pop_front());   // oldest lost
         end
      end
      rows.push_back(r);
   endtask

   // stream pending rows back to back and check each one cycle later
   task automatic run_table();
      int i;
      for (i = next_row; i <= rows.size(); i++) begin
         @(posedge s_clk);
         if (i < rows.size()) begin
            s_valid  <= 1'b1;
            s_pc     <= rows[i].pc;
            s_instr  <= rows[i].instr;
            s_target <= rows[i].target;
         end else begin
            s_valid <= 1'b0;
         end
         @(negedge s_clk);   // row i-1 sits in the op register now
         if (i > next_row && s_pred_valid !== rows[i-1].exp_valid) begin
            report_fail($sformatf("row %0d pred_valid %b, expected %b", i - 1,
                                  s_pred_valid, rows[i-1].exp_valid));
         end
         if (i > next_row && rows[i-1].exp_valid && s_pred_target !== rows[i-1].exp_target) begin
            report_fail($sformatf("row %0d pred_target %h, expected %h", i - 1,
                                  s_pred_target, rows[i-1].exp_target));
         end
      end
      next_row = rows.size();
   endtask

   // zero-wait transfer where data is the expected value on reads
   task automatic apb_xfer(input bit wr, input logic [APB_AW-1:0] addr,
                           input logic [XLEN-1:0] data, input bit exp_err);
      @(posedge s_clk);
      s_psel    <= 1'b1;   // setup
      s_penable <= 1'b0;
      s_pwrite  <= wr;
      s_paddr   <= addr;
      s_pwdata  <= data;
      @(posedge s_clk);
      s_penable <= 1'b1;   // access
      @(negedge s_clk);
      if (s_pready !== 1'b1) begin
         report_fail($sformatf("pready %b at addr %h, expected 1", s_pready, addr));
      end
      if (s_pslverr !== exp_err) begin
         report_fail($sformatf("pslverr %b at addr %h, expected %b", s_pslverr, addr, exp_err));
      end
      if (!wr && s_prdata !== data) begin
         report_fail($sformatf("read %h at addr %h, expected %h", s_prdata, addr, data));
      end
      @(posedge s_clk);    // transfer completes on this edge
      s_psel    <= 1'b0;
      s_penable <= 1'b0;
      n_apb++;
   endtask

   task automatic check_counters();
      apb_xfer(1'b0, ADDR_HITS, XLEN'(n_hits), 1'b0);
      apb_xfer(1'b0, ADDR_MISSES, XLEN'(n_misses), 1'b0);
      apb_xfer(1'b0, ADDR_EMPTY, XLEN'(n_empty), 1'b0);
   endtask

   always @(posedge s_clk) begin : watchdog
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin : main
      seed      = 27377;
      cycle_cnt = 0;
      n_errors  = 0;
      n_apb     = 0;
      next_row  = 0;
      model_en  = 1'b0;
      n_hits    = 0;
      n_misses  = 0;
      n_empty   = 0;
      s_resetn  = 1'b0;
      s_valid   = 1'b0;
      s_pc      = '0;
      s_instr   = '0;
      s_target  = '0;
      s_psel    = 1'b0;
      s_penable = 1'b0;
      s_pwrite  = 1'b0;
      s_paddr   = '0;
      s_pwdata  = '0;
      repeat (16) @(posedge s_clk);
      s_resetn <= 1'b1;
      @(negedge s_clk);
      if (s_pred_valid !== 1'b0 || s_pslverr !== 1'b0 || s_prdata !== '0) begin
         report_fail("outputs not idle after reset");
      end
      apb_xfer(1'b1, ADDR_CTRL, 32'h1, 1'b0);           // enable
      model_en = 1'b1;
      add_row(enc_jal(RA), 1, 0, 0);                     // nested calls
      add_row(enc_jalr(T0, ZERO), 1, 0, 0);              // indirect call through x5
      add_row(enc_jal(RA), 1, 0, 0);
      repeat (3) add_row(enc_jalr(ZERO, RA), 0, 1, 1);   // matching returns
      add_row(enc_jal(RA), 1, 0, 0);
      add_row(enc_jalr(ZERO, T0), 0, 1, 0);              // wrong target gives a miss
      add_row(enc_jalr(ZERO, 5'd6), 0, 0, 0);            // plain indirect jump
      repeat (2) add_row(enc_jalr(ZERO, RA), 0, 1, 1);   // empty stack
      repeat (9) add_row(enc_jal(RA), 1, 0, 0);          // one past depth
      repeat (9) add_row(enc_jalr(ZERO, RA), 0, 1, 1);
      repeat (2) add_row(enc_jal(RA), 1, 0, 0);
      add_row(enc_jalr(RA, T0), 1, 1, 1);                // coroutine swap
      repeat (2) add_row(enc_jalr(ZERO, RA), 0, 1, 1);
      add_row(enc_jal(RA), 1, 0, 0);                     // kept across the disable
      run_table();
      check_counters();
      apb_xfer(1'b1, ADDR_CTRL, 32'h0, 1'b0);           // disable
      apb_xfer(1'b0, ADDR_CTRL, 32'h0, 1'b0);
      model_en = 1'b0;
      repeat (2) add_row(enc_jal(RA), 1, 0, 0);
      repeat (2) add_row(enc_jalr(ZERO, RA), 0, 1, 1);
      run_table();
      check_counters();
      apb_xfer(1'b1, ADDR_CTRL, 32'h1, 1'b0);
      apb_xfer(1'b0, ADDR_CTRL, 32'h1, 1'b0);
      model_en = 1'b1;
      add_row(enc_jalr(ZERO, RA), 0, 1, 1);              // pops the kept entry
      run_table();
      check_counters();
      apb_xfer(1'b1, ADDR_HITS, 32'h1, 1'b1);           // counters are read only
      apb_xfer(1'b1, 4'h2, 32'h1, 1'b1);                // unmapped
      apb_xfer(1'b0, 4'h2, 32'h0, 1'b1);
      apb_xfer(1'b1, ADDR_CTRL, 32'h3, 1'b0);           // enable plus clear
      n_hits   = 0;
      n_misses = 0;
      n_empty  = 0;
      check_counters();
      apb_xfer(1'b0, ADDR_CTRL, 32'h1, 1'b0);           // clear bit reads back 0
      $display("errors: %0d, table rows: %0d, apb transfers: %0d", n_errors, rows.size(),
               n_apb);
      if (n_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/ras_asserts.sv
`default_nettype none

module ras_asserts (
   input logic s_clk_i,
   input logic s_resetn_i,
   input logic s_psel_i,
   input logic s_penable_i,
   input logic s_pready_i,
   input logic s_pslverr_i,
   input logic s_pred_valid_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // zero wait states, always ready
   a_pready_high: assert property (@(posedge s_clk_i) s_pready_i)
      else $error("apb pready went low");

   // op register still unknown before the first reset edge
   a_pred_quiet_in_reset: assert property (@(posedge s_clk_i)
      (!s_resetn_i && $past(!s_resetn_i)) |-> !s_pred_valid_i)
      else $error("prediction valid during reset");

   // error response only in access phase
   a_slverr_in_access: assert property (@(posedge s_clk_i)
      s_pslverr_i |-> (s_psel_i && s_penable_i))
      else $error("pslverr outside an apb access phase");

endmodule

bind ras_top ras_asserts u_asserts (
   .s_clk_i(s_clk_i), .s_resetn_i(s_resetn_i), .s_psel_i(s_psel_i),
   .s_penable_i(s_penable_i), .s_pready_i(s_pready_o), .s_pslverr_i(s_pslverr_o),
   .s_pred_valid_i(s_pred_valid_o));

`default_nettype wire

// File: hdl/ras_top.sv
`default_nettype none

module ras_top (
   input  logic                       s_clk_i,
   input  logic                       s_resetn_i,
   // retired jump stream, no back-pressure
   input  logic                       s_valid_i,
   input  logic [ras_pkg::XLEN-1:0]   s_pc_i,
   input  logic [ras_pkg::XLEN-1:0]   s_instr_i,
   input  logic [ras_pkg::XLEN-1:0]   s_target_i,
   // apb control and status
   input  logic                       s_psel_i,
   input  logic                       s_penable_i,
   input  logic                       s_pwrite_i,
   input  logic [ras_pkg::APB_AW-1:0] s_paddr_i,
   input  logic [ras_pkg::XLEN-1:0]   s_pwdata_i,
   output logic [ras_pkg::XLEN-1:0]   s_prdata_o,
   output logic                       s_pready_o,
   output logic                       s_pslverr_o,
   // prediction, combinational in the cycle after sampling
   output logic                       s_pred_valid_o,
   output logic [ras_pkg::XLEN-1:0]   s_pred_target_o
);

   import ras_pkg::*;

   ras_op_t          s_op;
   logic [XLEN-1:0]  s_ret_addr;
   logic [XLEN-1:0]  s_act_target;
   logic             s_push;
   logic             s_pop;
   logic             s_empty;
   logic [XLEN-1:0]  s_top;
   logic             s_enable;
   logic             s_clr;
   logic [CNT_W-1:0] s_hits;
   logic [CNT_W-1:0] s_misses;
   logic [CNT_W-1:0] s_empty_pops;

   // op to buffer strobes, poppush drives both
   assign s_push = (s_op == RAS_PUSH) || (s_op == RAS_POPPUSH);
   assign s_pop  = (s_op == RAS_POP)  || (s_op == RAS_POPPUSH);

   ras_decoder u_decoder (
      .s_clk_i(s_clk_i), .s_resetn_i(s_resetn_i), .s_enable_i(s_enable),
      .s_valid_i(s_valid_i), .s_pc_i(s_pc_i), .s_instr_i(s_instr_i),
      .s_target_i(s_target_i), .s_op_o(s_op), .s_ret_addr_o(s_ret_addr),
      .s_act_target_o(s_act_target));

   circular_buffer #(.SIZE(RAS_DEPTH), .WIDTH(XLEN)) u_stack (
      .s_clk_i(s_clk_i), .s_resetn_i(s_resetn_i), .s_push_i(s_push), .s_pop_i(s_pop),
      .s_data_i(s_ret_addr), .s_empty_o(s_empty), .s_data_o(s_top));

   ras_checker u_checker (
      .s_clk_i(s_clk_i), .s_resetn_i(s_resetn_i), .s_clr_i(s_clr), .s_op_i(s_op),
      .s_act_target_i(s_act_target), .s_top_i(s_top), .s_empty_i(s_empty),
      .s_pred_valid_o(s_pred_valid_o), .s_pred_target_o(s_pred_target_o),
      .s_hits_o(s_hits), .s_misses_o(s_misses), .s_empty_pops_o(s_empty_pops));

   ras_apb_regs u_regs (
      .s_clk_i(s_clk_i), .s_resetn_i(s_resetn_i), .s_psel_i(s_psel_i),
      .s_penable_i(s_penable_i), .s_pwrite_i(s_pwrite_i), .s_paddr_i(s_paddr_i),
      .s_pwdata_i(s_pwdata_i), .s_prdata_o(s_prdata_o), .s_pready_o(s_pready_o),
      .s_pslverr_o(s_pslverr_o), .s_hits_i(s_hits), .s_misses_i(s_misses),
      .s_empty_pops_i(s_empty_pops), .s_enable_o(s_enable), .s_clr_o(s_clr));

endmodule

`default_nettype wire

// File: hdl/ras_apb_regs.sv
`default_nettype none

module ras_apb_regs (
   input  logic                       s_clk_i,
   input  logic                       s_resetn_i,
   input  logic                       s_psel_i,
   input  logic                       s_penable_i,
   input  logic                       s_pwrite_i,
   input  logic [ras_pkg::APB_AW-1:0] s_paddr_i,
   input  logic [ras_pkg::XLEN-1:0]   s_pwdata_i,
   output logic [ras_pkg::XLEN-1:0]   s_prdata_o,
   output logic                       s_pready_o,
   output logic                       s_pslverr_o,
   input  logic [ras_pkg::CNT_W-1:0]  s_hits_i,
   input  logic [ras_pkg::CNT_W-1:0]  s_misses_i,
   input  logic [ras_pkg::CNT_W-1:0]  s_empty_pops_i,
   output logic                       s_enable_o,
   output logic                       s_clr_o        // single-cycle pulse
);

   import ras_pkg::*;

   logic            s_access;     // second apb cycle
   logic            s_addr_ok;
   logic            s_addr_cnt;   // counter address, read only
   logic            s_wr_ctrl;
   logic            s_enable;
   logic            s_clr;
   logic [XLEN-1:0] s_rdata;

   assign s_access = s_psel_i & s_penable_i;

   // address decode and read mux
   always_comb begin : decode
      s_addr_ok  = 1'b1;
      s_addr_cnt = 1'b0;
      s_rdata    = '0;
      case (s_paddr_i)
         ADDR_CTRL: s_rdata[CTRL_EN_BIT] = s_enable;   // clr reads as zero
         ADDR_HITS: begin
            s_addr_cnt = 1'b1;
            s_rdata    = XLEN'(s_hits_i);
         end
         ADDR_MISSES: begin
            s_addr_cnt = 1'b1;
            s_rdata    = XLEN'(s_misses_i);
         end
         ADDR_EMPTY: begin
            s_addr_cnt = 1'b1;
            s_rdata    = XLEN'(s_empty_pops_i);
         end
         default: s_addr_ok = 1'b0;                      // unmapped
      endcase
   end

   assign s_wr_ctrl = s_access & s_pwrite_i & (s_paddr_i == ADDR_CTRL);

   // control register, updates on the edge closing the access phase
   always_ff @(posedge s_clk_i) begin : ctrl_reg
      if (!s_resetn_i) begin
         s_enable <= 1'b0;
         s_clr    <= 1'b0;
      end else begin
         s_clr <= s_wr_ctrl & s_pwdata_i[CTRL_CLR_BIT];   // drops again next cycle
         if (s_wr_ctrl) begin
            s_enable <= s_pwdata_i[CTRL_EN_BIT];
         end
      end
   end

   assign s_pready_o  = 1'b1;                                   // zero wait states
   assign s_prdata_o  = (s_access & ~s_pwrite_i) ? s_rdata : '0;
   assign s_pslverr_o = s_access & (~s_addr_ok | (s_pwrite_i & s_addr_cnt));
   assign s_enable_o  = s_enable;
   assign s_clr_o     = s_clr;

endmodule

`default_nettype wire

// File: hdl/ras_checker.sv
`default_nettype none

module ras_checker (
   input  logic                      s_clk_i,
   input  logic                      s_resetn_i,
   input  logic                      s_clr_i,          // one-cycle counter clear
   input  ras_pkg::ras_op_t          s_op_i,
   input  logic [ras_pkg::XLEN-1:0]  s_act_target_i,
   input  logic [ras_pkg::XLEN-1:0]  s_top_i,          // stack top from buffer
   input  logic                      s_empty_i,
   output logic                      s_pred_valid_o,
   output logic [ras_pkg::XLEN-1:0]  s_pred_target_o,
   output logic [ras_pkg::CNT_W-1:0] s_hits_o,
   output logic [ras_pkg::CNT_W-1:0] s_misses_o,
   output logic [ras_pkg::CNT_W-1:0] s_empty_pops_o
);

   import ras_pkg::*;

   logic             s_is_pop;
   logic             s_pred_valid;
   logic             s_hit;
   logic             s_miss;
   logic             s_empty_pop;
   logic [CNT_W-1:0] s_hits;
   logic [CNT_W-1:0] s_misses;
   logic [CNT_W-1:0] s_empty_pops;

   // increment that sticks at all ones
   function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] cnt);
      return (&cnt) ? cnt : cnt + 1'b1;
   endfunction

   // a return consumes the top, coroutine swap included
   assign s_is_pop     = (s_op_i == RAS_POP) || (s_op_i == RAS_POPPUSH);
   assign s_pred_valid = s_is_pop & ~s_empty_i;
   assign s_empty_pop  = s_is_pop & s_empty_i;     // nothing to predict
   assign s_hit        = s_pred_valid & (s_top_i == s_act_target_i);
   assign s_miss       = s_pred_valid & (s_top_i != s_act_target_i);

   assign s_pred_valid_o  = s_pred_valid;
   assign s_pred_target_o = s_pred_valid ? s_top_i : '0;   // zero when no prediction

   // statistics, clear has priority over a same-cycle event
   always_ff @(posedge s_clk_i) begin : stats
      if (!s_resetn_i || s_clr_i) begin
         s_hits       <= '0;
         s_misses     <= '0;
         s_empty_pops <= '0;
      end else begin
         if (s_hit) begin
            s_hits <= sat_inc(s_hits);
         end
         if (s_miss) begin
            s_misses <= sat_inc(s_misses);
         end
         if (s_empty_pop) begin
            s_empty_pops <= sat_inc(s_empty_pops);
         end
      end
   end

   assign s_hits_o       = s_hits;
   assign s_misses_o     = s_misses;
   assign s_empty_pops_o = s_empty_pops;

endmodule

`default_nettype wire

// File: hdl/ras_decoder.sv
`default_nettype none

module ras_decoder (
   input  logic                     s_clk_i,
   input  logic                     s_resetn_i,
   input  logic                     s_enable_i,     // from control register
   input  logic                     s_valid_i,
   input  logic [ras_pkg::XLEN-1:0] s_pc_i,
   input  logic [ras_pkg::XLEN-1:0] s_instr_i,
   input  logic [ras_pkg::XLEN-1:0] s_target_i,     // resolved jump target
   output ras_pkg::ras_op_t         s_op_o,
   output logic [ras_pkg::XLEN-1:0] s_ret_addr_o,   // pc + 4
   output logic [ras_pkg::XLEN-1:0] s_act_target_o
);

   import ras_pkg::*;

   logic [6:0] s_opcode;
   logic [4:0] s_rd;
   logic [4:0] s_rs1;
   logic       s_rd_link;
   logic       s_rs1_link;
   ras_op_t    s_op_d;

   // x1 or x5 count as link registers
   function automatic logic is_link(input logic [4:0] reg_idx);
      return (reg_idx == LINK_X1) || (reg_idx == LINK_X5);
   endfunction

   // i/j type field positions
   assign s_opcode   = s_instr_i[6:0];
   assign s_rd       = s_instr_i[11:7];
   assign s_rs1      = s_instr_i[19:15];
   assign s_rd_link  = is_link(s_rd);
   assign s_rs1_link = is_link(s_rs1);

   // link-register hint table
   always_comb begin : classify
      s_op_d = RAS_NONE;
      if (s_valid_i && s_enable_i) begin
         if (s_opcode == OPC_JAL) begin
            if (s_rd_link) begin
               s_op_d = RAS_PUSH;             // call
            end
         end else if (s_opcode == OPC_JALR) begin
            case ({s_rd_link, s_rs1_link})
               2'b10:   s_op_d = RAS_PUSH;    // indirect call
               2'b01:   s_op_d = RAS_POP;     // return
               2'b11: begin
                  // same reg means call, different means coroutine swap
                  s_op_d = (s_rd == s_rs1) ? RAS_PUSH : RAS_POPPUSH;
               end
               default: s_op_d = RAS_NONE;    // plain indirect jump
            endcase
         end
      end
   end

   // op register, one stage before stack update
   always_ff @(posedge s_clk_i) begin : op_reg
      if (!s_resetn_i) begin
         s_op_o <= RAS_NONE;
      end else begin
         s_op_o <= s_op_d;
      end
   end

   // payload only loaded with a valid instruction
   always_ff @(posedge s_clk_i) begin : payload_reg
      if (s_valid_i) begin
         s_ret_addr_o   <= s_pc_i + XLEN'(4);   // no compressed support
         s_act_target_o <= s_target_i;
      end
   end

endmodule

`default_nettype wire

// File: hdl/circular_buffer.sv
`default_nettype none

module circular_buffer #(
   parameter int SIZE  = 4,
   parameter int WIDTH = 32
) (
   input  logic             s_clk_i,
   input  logic             s_resetn_i,
   input  logic             s_push_i,    // push, or replace top together with pop
   input  logic             s_pop_i,
   input  logic [WIDTH-1:0] s_data_i,    // value to push
   output logic             s_empty_o,
   output logic [WIDTH-1:0] s_data_o     // current top, combinational
);

   localparam int PTRW = (SIZE > 1) ? $clog2(SIZE) : 1;
   localparam logic [PTRW:0]   CNT_FULL = (PTRW+1)'(SIZE);
   localparam logic [PTRW-1:0] PTR_LAST = PTRW'(SIZE - 1);

   logic [WIDTH-1:0] s_mem [SIZE];   // stack storage
   logic [PTRW-1:0]  s_top_ptr;      // slot of last pushed entry
   logic [PTRW:0]    s_count;        // valid entries, saturates at SIZE
   logic [PTRW-1:0]  s_ptr_up;
   logic [PTRW-1:0]  s_ptr_dn;
   logic [PTRW-1:0]  s_wpos;         // slot written on push
   logic             s_empty;
   logic             s_full;
   logic             s_do_push;
   logic             s_do_pop;
   logic             s_do_repl;

   assign s_empty = (s_count == '0);
   assign s_full  = (s_count == CNT_FULL);

   // pointer moves with wrap, SIZE need not be a power of two
   assign s_ptr_up = (s_top_ptr == PTR_LAST) ? '0 : s_top_ptr + PTRW'(1);
   assign s_ptr_dn = (s_top_ptr == '0) ? PTR_LAST : s_top_ptr - PTRW'(1);

   // push+pop on a live stack rewrites the top in place
   assign s_do_repl = s_push_i & s_pop_i & ~s_empty;
   // pop half of push+pop is dropped when empty
   assign s_do_push = s_push_i & ~s_do_repl;
   assign s_do_pop  = s_pop_i & ~s_push_i & ~s_empty;   // empty pop ignored

   assign s_wpos = s_do_repl ? s_top_ptr : s_ptr_up;

   // pointer and occupancy
   always_ff @(posedge s_clk_i) begin : ctrl
      if (!s_resetn_i) begin
         s_top_ptr <= '0;
         s_count   <= '0;
      end else if (s_do_push) begin
         s_top_ptr <= s_ptr_up;            // on full this lands on the oldest slot
         if (!s_full) begin
            s_count <= s_count + 1'b1;
         end
      end else if (s_do_pop) begin
         s_top_ptr <= s_ptr_dn;
         s_count   <= s_count - 1'b1;
      end
   end

   // entry write, covers plain push and in-place replace
   always_ff @(posedge s_clk_i) begin : store
      if (s_push_i) begin
         s_mem[s_wpos] <= s_data_i;
      end
   end

   assign s_empty_o = s_empty;
   assign s_data_o  = s_mem[s_top_ptr];   // stale when empty, qualify with s_empty_o

endmodule

`default_nettype wire

// File: hdl/ras_pkg.sv
`default_nettype none

package ras_pkg;

   // datapath and stack sizing
   localparam int XLEN      = 32;   // pc, targets, apb data
   localparam int RAS_DEPTH = 8;    // stack entries
   localparam int CNT_W     = 16;   // statistics counter width
   localparam int APB_AW    = 4;    // apb byte address width

   // rv32i jump opcodes
   localparam logic [6:0] OPC_JAL  = 7'b1101111;
   localparam logic [6:0] OPC_JALR = 7'b1100111;

   // link registers per the hint table
   localparam logic [4:0] LINK_X1 = 5'd1;   // ra
   localparam logic [4:0] LINK_X5 = 5'd5;   // t0, alternate link

   // stack operation from decoder
   typedef enum logic [1:0] {
      RAS_NONE    = 2'd0,
      RAS_PUSH    = 2'd1,
      RAS_POP     = 2'd2,
      RAS_POPPUSH = 2'd3    // coroutine swap
   } ras_op_t;

   // apb register map, byte addresses
   localparam logic [APB_AW-1:0] ADDR_CTRL   = 4'h0;
   localparam logic [APB_AW-1:0] ADDR_HITS   = 4'h4;   // read only
   localparam logic [APB_AW-1:0] ADDR_MISSES = 4'h8;   // read only
   localparam logic [APB_AW-1:0] ADDR_EMPTY  = 4'hC;   // read only

   // control register fields
   localparam int CTRL_EN_BIT  = 0;   // predictor enable
   localparam int CTRL_CLR_BIT = 1;   // counter clear strobe, self clearing

endpackage

`default_nettype wire
